// File: filelist.f
hdl/stream_pkg.sv
hdl/cdc_pkg.sv
hdl/gray_sync.sv
hdl/cdc_fifo.sv
hdl/beat_narrower.sv
hdl/width_change_cdc_top.sv
dv/width_change_assertions.sv
dv/tb_width_change.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_width_change -f filelist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/tb_width_change.sv
// Random packets of 1 to 40 bytes with one fixed seed, clock a is 6 ns and clock b is 4 ns
`timescale 1ns/1ns

module tb_width_change;

  localparam int NUM_PKTS = 60;
  localparam int MAX_LEN  = 40;
  localparam int WB       = stream_pkg::WIDE_BYTS;
  localparam int NB       = stream_pkg::NARROW_BYTS;
  localparam int WMB      = stream_pkg::WIDE_MOD_BITS;
  localparam int NMB      = stream_pkg::NARROW_MOD_BITS;

  logic                     clk_a;
  logic                     clk_b;
  logic                     rst_a;
  logic                     rst_b;
  logic                     val_a;
  stream_pkg::wide_beat_t   beat_a;
  logic                     rdy_a;
  logic                     val_b;
  stream_pkg::narrow_beat_t beat_b;
  logic                     rdy_b;

  integer seed = 81662;
  int     errors;
  int     out_count;
  int     exp_count;
  int     total_byts;
  logic   gen_done;

  stream_pkg::wide_beat_t   in_q  [$];  // Wide beats still to be driven
  stream_pkg::narrow_beat_t exp_q [$];  // Narrow beats still to be seen

  initial clk_a = 1'b0;
  initial clk_b = 1'b0;
  always #3 clk_a = ~clk_a;
  always #2 clk_b = ~clk_b;

  width_change_cdc_top #(
    .FIFO_ABITS  ( 3                       ),
    .SYNC_STAGES ( cdc_pkg::SYNC_STAGES_DEF )
  ) UUT (
    .i_clk_a  ( clk_a  ),
    .i_rst_a  ( rst_a  ),
    .i_clk_b  ( clk_b  ),
    .i_rst_b  ( rst_b  ),
    .i_val_a  ( val_a  ),
    .i_beat_a ( beat_a ),
    .o_rdy_a  ( rdy_a  ),
    .o_val_b  ( val_b  ),
    .o_beat_b ( beat_b ),
    .i_rdy_b  ( rdy_b  )
  );

  // One packet becomes wide input beats and the narrow beats expected from them
  task automatic build_packet();
    logic [7:0]               pkt [MAX_LEN];
    int                       len;
    int                       nwrd;
    int                       nslc;
    logic [7:0]               ctl;
    stream_pkg::wide_beat_t   wb;
    stream_pkg::narrow_beat_t nb;
    len = 1 + ($unsigned($random(seed)) % MAX_LEN);
    ctl = 8'($random(seed));
    total_byts += len;
    for (int i = 0; i < len; i++) begin
      pkt[i] = 8'($random(seed));
    end
    nwrd = (len + WB - 1) / WB;
    for (int w = 0; w < nwrd; w++) begin
      wb.dat = {$random(seed), $random(seed)};  // Filler beyond the last byte
      for (int j = 0; j < WB; j++) begin
        if (w * WB + j < len) begin
          wb.dat[j*8 +: 8] = pkt[w*WB + j];
        end
      end
      wb.sop = (w == 0);
      wb.eop = (w == nwrd - 1);
      wb.mod = wb.eop ? WMB'(len % WB) : '0;
      wb.ctl = ctl;
      in_q.push_back(wb);
    end
    nslc = (len + NB - 1) / NB;  // Slices follow the packet bytes two at a time
    for (int s = 0; s < nslc; s++) begin
      nb.dat = '0;
      for (int j = 0; j < NB; j++) begin
        if (s * NB + j < len) begin
          nb.dat[j*8 +: 8] = pkt[s*NB + j];
        end
      end
      nb.sop = (s == 0);
      nb.eop = (s == nslc - 1);
      nb.mod = nb.eop ? NMB'(len % NB) : '0;
      nb.ctl = ctl;
      exp_q.push_back(nb);
    end
  endtask

  task automatic check_beat(input stream_pkg::narrow_beat_t got);
    stream_pkg::narrow_beat_t exp;
    logic [NB*8-1:0]          mask;
    int                       nvld;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("output beat seen after all expected beats were used, dat %h", got.dat);
    end
    if (exp_q.size() != 0) begin
      exp  = exp_q.pop_front();
      nvld = (exp.eop && exp.mod != '0) ? int'(exp.mod) : NB;
      mask = '0;
      for (int j = 0; j < nvld; j++) begin
        mask[j*8 +: 8] = 8'hff;  // Bytes past mod carry no data
      end
      assert ((got.dat & mask) === (exp.dat & mask)) else begin
        errors++;
        $display("mismatch o_beat_b.dat beat %0d: got %h expected %h", out_count,
                 got.dat & mask, exp.dat & mask);
      end
      assert (got.mod === exp.mod) else begin
        errors++;
        $display("mismatch o_beat_b.mod beat %0d: got %h expected %h", out_count, got.mod, exp.mod);
      end
      assert (got.sop === exp.sop) else begin
        errors++;
        $display("mismatch o_beat_b.sop beat %0d: got %h expected %h", out_count, got.sop, exp.sop);
      end
      assert (got.eop === exp.eop) else begin
        errors++;
        $display("mismatch o_beat_b.eop beat %0d: got %h expected %h", out_count, got.eop, exp.eop);
      end
      assert (got.ctl === exp.ctl) else begin
        errors++;
        $display("mismatch o_beat_b.ctl beat %0d: got %h expected %h", out_count, got.ctl, exp.ctl);
      end
    end
    out_count++;
  endtask

  task automatic hold_reset_a();
    @(posedge clk_a);
    repeat (2) begin
      @(negedge clk_a);
      assert (rdy_a === 1'b0) else begin
        errors++;
        $display("o_rdy_a is not low while reset a is asserted");
      end
      @(posedge clk_a);
    end
    #1;
    rst_a = 1'b0;
  endtask

  task automatic hold_reset_b();
    @(posedge clk_b);
    repeat (2) begin
      @(negedge clk_b);
      assert (val_b === 1'b0) else begin
        errors++;
        $display("o_val_b is not low while reset b is asserted");
      end
      @(posedge clk_b);
    end
    #1;
    rst_b = 1'b0;
  endtask

  task automatic drive_beats();
    stream_pkg::wide_beat_t wb;
    logic                   acc;
    int                     gap;
    while (in_q.size() != 0) begin
      wb     = in_q.pop_front();
      val_a  = 1'b1;
      beat_a = wb;
      acc    = 1'b0;
      while (!acc) begin
        @(negedge clk_a);
        acc = rdy_a;  // Ready seen here holds through the next edge
        @(posedge clk_a);
        #1;
      end
      val_a = 1'b0;
      gap   = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk_a);
        #1;
      end
    end
  endtask

  // Sink ready, about 30% low
  always @(posedge clk_b) begin
    #1;
    rdy_b = ($unsigned($random(seed)) % 10) >= 3;
  end

  always @(negedge clk_b) begin
    if (rst_b === 1'b0 && val_b === 1'b1 && rdy_b === 1'b1) begin
      check_beat(beat_b);
    end
  end

  initial begin
    rst_a      = 1'b1;
    rst_b      = 1'b1;
    val_a      = 1'b0;
    beat_a     = '0;
    rdy_b      = 1'b0;
    errors     = 0;
    out_count  = 0;
    total_byts = 0;
    gen_done   = 1'b0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      build_packet();
    end
    exp_count = exp_q.size();
    gen_done  = 1'b1;
    fork
      hold_reset_a();
      hold_reset_b();
    join
    @(posedge clk_a);
    #1;
    drive_beats();
    while (exp_q.size() != 0) begin
      @(negedge clk_b);
    end
    repeat (20) @(negedge clk_b);  // Leaves room for a duplicate beat to appear
    assert (out_count == exp_count) else begin
      errors++;
      $display("saw %0d output beats where %0d were expected", out_count, exp_count);
    end
    errors += UUT.u_assertions.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Allows 4 ns per byte, four times over, plus start-up time
  initial begin
    wait (gen_done === 1'b1);
    #(total_byts * 16 + 2000);
    $display("watchdog expired with %0d output beats still expected", exp_q.size());
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: dv/width_change_assertions.sv
// Watches the top-level stream ports only and needs both resets asserted from time zero
`timescale 1ns/1ns

module width_change_assertions (
  input logic                     i_clk_a,
  input logic                     i_rst_a,
  input logic                     i_clk_b,
  input logic                     i_rst_b,
  input logic                     i_rdy_a,
  input logic                     i_val_b,
  input stream_pkg::narrow_beat_t i_beat_b,
  input logic                     i_rdy_b
);

  int fail_count = 0;  // Assertion failures so far

  // A stalled output beat must wait for the sink
  a_hold_val: assert property (@(posedge i_clk_b) disable iff (i_rst_b)
    (i_val_b && !i_rdy_b) |=> i_val_b)
    else begin
      $error("o_val_b fell while the sink held i_rdy_b low");
      fail_count++;
    end

  a_hold_beat: assert property (@(posedge i_clk_b) disable iff (i_rst_b)
    (i_val_b && !i_rdy_b) |=> $stable(i_beat_b))
    else begin
      $error("o_beat_b changed while the sink held i_rdy_b low");
      fail_count++;
    end

  a_rst_val: assert property (@(posedge i_clk_b) i_rst_b |=> !i_val_b)
    else begin
      $error("o_val_b high after a reset b edge");
      fail_count++;
    end

  a_rst_rdy: assert property (@(posedge i_clk_a) i_rst_a |=> !i_rdy_a)
    else begin
      $error("o_rdy_a high after a reset a edge");
      fail_count++;
    end

endmodule

bind width_change_cdc_top width_change_assertions u_assertions (
  .i_clk_a  ( i_clk_a  ),
  .i_rst_a  ( i_rst_a  ),
  .i_clk_b  ( i_clk_b  ),
  .i_rst_b  ( i_rst_b  ),
  .i_rdy_a  ( o_rdy_a  ),
  .i_val_b  ( o_val_b  ),
  .i_beat_b ( o_beat_b ),
  .i_rdy_b  ( i_rdy_b  )
);

// File: hdl/width_change_cdc_top.sv
// Wide to narrow packet stream across two clocks. FIFO depth is 2**FIFO_ABITS wide beats
`timescale 1ns/1ns

module width_change_cdc_top #(
  parameter int FIFO_ABITS  = 3,
  parameter int SYNC_STAGES = cdc_pkg::SYNC_STAGES_DEF
) (
  input  logic                     i_clk_a,
  input  logic                     i_rst_a,
  input  logic                     i_clk_b,
  input  logic                     i_rst_b,
  input  logic                     i_val_a,
  input  stream_pkg::wide_beat_t   i_beat_a,
  output logic                     o_rdy_a,
  output logic                     o_val_b,
  output stream_pkg::narrow_beat_t o_beat_b,
  input  logic                     i_rdy_b
);

  logic                   fifo_val;   // Head word present in clock b
  stream_pkg::wide_beat_t fifo_beat;
  logic                   fifo_pop;   // Narrower is done with the head word

  cdc_fifo #(
    .T_PAYLOAD   ( stream_pkg::wide_beat_t ),
    .ABITS       ( FIFO_ABITS              ),
    .SYNC_STAGES ( SYNC_STAGES             )
  ) u_fifo (
    .i_clk_a ( i_clk_a   ),
    .i_rst_a ( i_rst_a   ),
    .i_val_a ( i_val_a   ),
    .i_dat_a ( i_beat_a  ),
    .o_rdy_a ( o_rdy_a   ),
    .i_clk_b ( i_clk_b   ),
    .i_rst_b ( i_rst_b   ),
    .o_val_b ( fifo_val  ),
    .o_dat_b ( fifo_beat ),
    .i_pop_b ( fifo_pop  )
  );

  beat_narrower u_narrower (
    .i_clk_b ( i_clk_b   ),
    .i_rst_b ( i_rst_b   ),
    .i_val   ( fifo_val  ),
    .i_beat  ( fifo_beat ),
    .o_pop   ( fifo_pop  ),
    .o_val   ( o_val_b   ),
    .o_beat  ( o_beat_b  ),
    .i_rdy   ( i_rdy_b   )
  );

endmodule

// File: hdl/beat_narrower.sv
// Splits each wide beat into NARROW_BYTS slices and mod is only honoured on eop words
`timescale 1ns/1ns

module beat_narrower (
  input  logic                    i_clk_b,
  input  logic                    i_rst_b,
  input  logic                    i_val,
  input  stream_pkg::wide_beat_t  i_beat,
  output logic                    o_pop,
  output logic                    o_val,
  output stream_pkg::narrow_beat_t o_beat,
  input  logic                    i_rdy
);

  localparam int NB      = stream_pkg::NARROW_BYTS;
  localparam int WB      = stream_pkg::WIDE_BYTS;
  localparam int RATIO   = WB / NB;
  localparam int SL_BITS = (RATIO == 1) ? 1 : $clog2(RATIO);
  localparam int BC_BITS = $clog2(WB) + 1;  // Holds a byte count up to WB
  localparam int NM_BITS = stream_pkg::NARROW_MOD_BITS;

  logic [SL_BITS-1:0]       slc_q;     // Slice of the head word to send next
  logic                     val_q;
  stream_pkg::narrow_beat_t beat_q;
  stream_pkg::narrow_beat_t beat_nxt;

  logic [BC_BITS-1:0] wrd_byts;  // Valid bytes in the head word
  logic [BC_BITS-1:0] byt_off;   // First byte of the current slice
  logic [BC_BITS-1:0] byt_rem;   // Bytes from this slice to the end of the word
  logic               last_slc;
  logic               load;

  always_comb begin
    if (i_beat.eop && i_beat.mod != '0) begin
      wrd_byts = BC_BITS'(i_beat.mod);
    end else begin
      wrd_byts = BC_BITS'(WB);
    end
  end

  assign byt_off  = BC_BITS'(slc_q) * BC_BITS'(NB);
  assign byt_rem  = wrd_byts - byt_off;
  assign last_slc = (byt_rem <= BC_BITS'(NB));

  // Take a slice whenever the output register is free or being emptied
  assign load  = i_val & (~val_q | i_rdy);
  assign o_pop = load & last_slc;

  always_comb begin
    beat_nxt.dat = i_beat.dat[byt_off*8 +: NB*8];
    beat_nxt.sop = i_beat.sop & (slc_q == '0);
    beat_nxt.eop = i_beat.eop & last_slc;
    beat_nxt.ctl = i_beat.ctl;
    if (beat_nxt.eop && byt_rem < BC_BITS'(NB)) begin
      beat_nxt.mod = NM_BITS'(byt_rem);  // Short final slice
    end else begin
      beat_nxt.mod = '0;
    end
  end

  always_ff @(posedge i_clk_b) begin
    if (i_rst_b) begin
      slc_q <= '0;
      val_q <= 1'b0;
    end else if (load) begin
      slc_q <= last_slc ? '0 : slc_q + SL_BITS'(1);
      val_q <= 1'b1;
    end else if (i_rdy) begin
      val_q <= 1'b0;  // Slice accepted and nothing to follow
    end
  end

  always_ff @(posedge i_clk_b) begin
    if (load) begin
      beat_q <= beat_nxt;
    end
  end

  assign o_val  = val_q;
  assign o_beat = beat_q;

endmodule

// File: hdl/cdc_fifo.sv
// Dual-clock FIFO with gray pointers. ABITS must be 2 or more and read data is not registered
`timescale 1ns/1ns

module cdc_fifo #(
  parameter type T_PAYLOAD   = logic [7:0],
  parameter int  ABITS       = 3,
  parameter int  SYNC_STAGES = 2
) (
  input  logic     i_clk_a,
  input  logic     i_rst_a,
  input  logic     i_val_a,
  input  T_PAYLOAD i_dat_a,
  output logic     o_rdy_a,
  input  logic     i_clk_b,
  input  logic     i_rst_b,
  output logic     o_val_b,
  output T_PAYLOAD o_dat_b,
  input  logic     i_pop_b
);

  localparam int DEPTH = 1 << ABITS;
  localparam int PW    = ABITS + 1;  // Extra wrap bit tells full from empty
  localparam int MW    = cdc_pkg::PTR_MAX_BITS;

  T_PAYLOAD mem [DEPTH];

  // Write side, clock a
  logic [PW-1:0] wr_bin_q, wr_gray_q;
  logic [PW-1:0] wr_bin_nxt, wr_gray_nxt;
  logic [PW-1:0] rd_gray_a;  // Read pointer seen in clock a
  logic [PW-1:0] full_cmp;
  logic          rdy_q;
  logic          wr_en;

  // Read side, clock b
  logic [PW-1:0] rd_bin_q, rd_gray_q;
  logic [PW-1:0] rd_bin_nxt;
  logic [PW-1:0] wr_gray_b;  // Write pointer seen in clock b
  logic          rd_en;

  assign wr_en       = i_val_a & rdy_q;
  assign wr_bin_nxt  = wr_bin_q + PW'(wr_en);
  assign wr_gray_nxt = PW'(cdc_pkg::bin2gray(MW'(wr_bin_nxt)));

  // Full when the write pointer is one lap ahead of the read pointer
  assign full_cmp = {~rd_gray_a[PW-1 -: 2], rd_gray_a[PW-3:0]};

  always_ff @(posedge i_clk_a) begin
    if (i_rst_a) begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
      rdy_q     <= 1'b0;
    end else begin
      wr_bin_q  <= wr_bin_nxt;
      wr_gray_q <= wr_gray_nxt;
      rdy_q     <= (wr_gray_nxt != full_cmp);  // Looks one write ahead
    end
  end

  always_ff @(posedge i_clk_a) begin
    if (wr_en) begin
      mem[wr_bin_q[ABITS-1:0]] <= i_dat_a;
    end
  end

  assign o_rdy_a = rdy_q;

  gray_sync #(
    .WIDTH  ( PW          ),
    .STAGES ( SYNC_STAGES )
  ) rd_ptr_sync (
    .i_clk_b ( i_clk_a   ),
    .i_rst_b ( i_rst_a   ),
    .i_gray  ( rd_gray_q ),
    .o_gray  ( rd_gray_a )
  );

  gray_sync #(
    .WIDTH  ( PW          ),
    .STAGES ( SYNC_STAGES )
  ) wr_ptr_sync (
    .i_clk_b ( i_clk_b   ),
    .i_rst_b ( i_rst_b   ),
    .i_gray  ( wr_gray_q ),
    .o_gray  ( wr_gray_b )
  );

  assign o_val_b    = (rd_gray_q != wr_gray_b);  // Not empty
  assign rd_en      = i_pop_b & o_val_b;
  assign rd_bin_nxt = rd_bin_q + PW'(rd_en);

  always_ff @(posedge i_clk_b) begin
    if (i_rst_b) begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end else begin
      rd_bin_q  <= rd_bin_nxt;
      rd_gray_q <= PW'(cdc_pkg::bin2gray(MW'(rd_bin_nxt)));
    end
  end

  // Head word read straight from the array
  assign o_dat_b = mem[rd_bin_q[ABITS-1:0]];

endmodule

// File: hdl/gray_sync.sv
// Only gray-coded values may pass through here since each bit is sampled on its own
`timescale 1ns/1ns

module gray_sync #(
  parameter int WIDTH  = 4,
  parameter int STAGES = 2
) (
  input  logic             i_clk_b,
  input  logic             i_rst_b,
  input  logic [WIDTH-1:0] i_gray,
  output logic [WIDTH-1:0] o_gray
);

  logic [WIDTH-1:0] sync_q [STAGES];  // Stage 0 samples the foreign domain

  always_ff @(posedge i_clk_b) begin
    if (i_rst_b) begin
      for (int i = 0; i < STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= i_gray;
      for (int i = 1; i < STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign o_gray = sync_q[STAGES-1];

endmodule

// File: hdl/cdc_pkg.sv
// Gray conversion helpers work on pointers of at most PTR_MAX_BITS bits, zero extended
package cdc_pkg;

  // Default number of flops in a pointer synchronizer
  localparam int SYNC_STAGES_DEF = 2;

  // Widest pointer the conversion functions accept
  localparam int PTR_MAX_BITS = 16;

  function automatic logic [PTR_MAX_BITS-1:0] bin2gray(input logic [PTR_MAX_BITS-1:0] i_bin);
    return i_bin ^ (i_bin >> 1);
  endfunction

  function automatic logic [PTR_MAX_BITS-1:0] gray2bin(input logic [PTR_MAX_BITS-1:0] i_gray);
    logic [PTR_MAX_BITS-1:0] bin;
    bin[PTR_MAX_BITS-1] = i_gray[PTR_MAX_BITS-1];
    for (int i = PTR_MAX_BITS - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ i_gray[i];  // Running XOR from the top bit down
    end
    return bin;
  endfunction

endpackage

// File: hdl/stream_pkg.sv
// Beat layouts are fixed here and WIDE_BYTS must be a power-of-two multiple of NARROW_BYTS
package stream_pkg;

  // Bytes carried by one beat on the input side
  localparam int WIDE_BYTS = 8;

  // Bytes carried by one beat on the output side
  localparam int NARROW_BYTS = 2;

  // Width of the control word copied along with every beat
  localparam int CTL_BITS = 8;

  localparam int WIDE_MOD_BITS   = (WIDE_BYTS == 1) ? 1 : $clog2(WIDE_BYTS);
  localparam int NARROW_MOD_BITS = (NARROW_BYTS == 1) ? 1 : $clog2(NARROW_BYTS);

  // Input beat, least significant byte first
  typedef struct packed {
    logic [WIDE_BYTS*8-1:0]   dat;  // Payload bytes
    logic [WIDE_MOD_BITS-1:0] mod;  // Valid byte count on eop, 0 means all valid
    logic                     sop;  // First beat of a packet
    logic                     eop;  // Last beat of a packet
    logic [CTL_BITS-1:0]      ctl;  // Per-packet control word
  } wide_beat_t;

  // Output beat, one slice of a wide beat
  typedef struct packed {
    logic [NARROW_BYTS*8-1:0]   dat;  // Payload bytes
    logic [NARROW_MOD_BITS-1:0] mod;  // Valid byte count on eop, 0 means all valid
    logic                       sop;  // First slice of a packet
    logic                       eop;  // Slice holding the final byte of a packet
    logic [CTL_BITS-1:0]        ctl;  // Copied from the wide beat
  } narrow_beat_t;

endpackage
